// ==== dv/fdam_accelerator_tb.sv ====
`timescale 1ns/1ps
`include "fdam_consts.svh"

module fdam_accelerator_tb
  import fdam_conf_pkg::*;
  import fdam_stream_pkg::*;
();

  localparam int RESET_CYCLES = 8;
  localparam int MAX_ITEMS = 64;
  localparam int HEADER_WORDS = 7;
  localparam int DRAIN_CYCLES = 6;
  localparam qid_t STATUS_QID = qid_t'(`FDAM_NUM_IN + `FDAM_NUM_OUT);

  logic clk;
  logic reset;
  logic start;
  logic conf_valid;
  conf_word_t conf;
  logic [`FDAM_NUM_IN-1:0] available_read;
  logic [`FDAM_NUM_IN-1:0] request_read;
  addr_t [`FDAM_NUM_IN-1:0] request_data;
  logic read_data_valid;
  qid_t read_queue_id;
  data_t read_data;
  logic [`FDAM_NUM_OUT:0] available_write;
  logic [`FDAM_NUM_OUT:0] request_write;
  wr_beat_t [`FDAM_NUM_OUT:0] write_data;
  logic write_data_valid;
  qid_t write_queue_id;

  data_t case_mem [256];
  data_t host_mem [65536];
  data_t op_a [MAX_ITEMS];
  data_t op_b [MAX_ITEMS];

  int cycle_cnt = 0;
  int cycle_limit;
  logic [31:0] rng;
  int item_cnt;
  logic stall;
  addr_t in_base [`FDAM_NUM_IN];
  addr_t out_base [`FDAM_NUM_OUT];
  addr_t status_addr;
  int rd_seen [`FDAM_NUM_IN];
  int wr_seen [`FDAM_NUM_OUT];
  int status_seen;
  int res_acks_sent;
  logic status_acked;
  int case_errors;
  int total_errors;
  int cases_passed;
  int cases_failed;

  // one entry per pending host read or ack
  int rd_due [$];
  qid_t rd_qid [$];
  addr_t rd_addr [$];
  int ack_due [$];
  qid_t ack_qid [$];

  fdam_accelerator u_dut (
    .clk              (clk),
    .reset            (reset),
    .start            (start),
    .conf_valid       (conf_valid),
    .conf             (conf),
    .available_read   (available_read),
    .request_read     (request_read),
    .request_data     (request_data),
    .read_data_valid  (read_data_valid),
    .read_queue_id    (read_queue_id),
    .read_data        (read_data),
    .available_write  (available_write),
    .request_write    (request_write),
    .write_data       (write_data),
    .write_data_valid (write_data_valid),
    .write_queue_id   (write_queue_id)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("timeout after %0d cycles, the accelerator never finished", cycle_limit);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic record_error(input string text);
    $display("%s", text);
    case_errors++;
    total_errors++;
  endtask

  // ==========================================================================
  // reset and configuration
  // ==========================================================================

  task automatic apply_reset();
    @(negedge clk);
    reset = 1'b1;
    start = 1'b0;
    conf_valid = 1'b0;
    read_data_valid = 1'b0;
    write_data_valid = 1'b0;
    available_read = '1;
    available_write = '1;
    rd_due.delete();
    rd_qid.delete();
    rd_addr.delete();
    ack_due.delete();
    ack_qid.delete();
    repeat (RESET_CYCLES - 1) @(negedge clk);
    #1;
    if (request_read !== '0) record_error("read request active during reset");
    if (request_write !== '0) record_error("write request active during reset");
    @(negedge clk);
    reset = 1'b0;
    // reset tree still draining
    repeat (3) @(negedge clk);
    #1;
    if (request_read !== '0) record_error("read request active after reset");
    if (request_write !== '0) record_error("write request active after reset");
  endtask

  task automatic send_conf(input int id, input addr_t base);
    @(negedge clk);
    conf_valid = 1'b1;
    conf.qid = qid_t'(id);
    conf.base = base;
    conf.count = qtd_t'(item_cnt);
  endtask

  task automatic configure_and_start();
    for (int q = 0; q < `FDAM_NUM_IN; q++) send_conf(q, in_base[q]);
    for (int k = 0; k < `FDAM_NUM_OUT; k++) send_conf(`FDAM_NUM_IN + k, out_base[k]);
    send_conf(int'(STATUS_QID), status_addr);
    @(negedge clk);
    conf_valid = 1'b0;
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
  endtask

  task automatic clear_tracking();
    rd_seen = '{default: 0};
    wr_seen = '{default: 0};
    status_seen = 0;
    res_acks_sent = 0;
    status_acked = 1'b0;
  endtask

  // ==========================================================================
  // host model for one cycle
  // ==========================================================================

  task automatic step_host();
    int i;
    addr_t exp_addr;
    data_t exp_data;
    @(negedge clk);
    if (stall) begin
      rng = xorshift32(rng);
      available_read = {rng[3] | rng[2], rng[1] | rng[0]};
      available_write = {rng[9] | rng[8], rng[7] | rng[6], rng[5] | rng[4]};
    end else begin
      available_read = '1;
      available_write = '1;
    end
    read_data_valid = 1'b0;
    if (rd_due.size() > 0 && rd_due[0] <= cycle_cnt) begin
      read_data_valid = 1'b1;
      read_queue_id = rd_qid.pop_front();
      read_data = host_mem[rd_addr.pop_front()];
      rd_due.delete(0);
    end
    write_data_valid = 1'b0;
    if (ack_due.size() > 0 && ack_due[0] <= cycle_cnt) begin
      write_data_valid = 1'b1;
      write_queue_id = ack_qid.pop_front();
      ack_due.delete(0);
      if (write_queue_id == STATUS_QID) status_acked = 1'b1;
      else res_acks_sent++;
    end
    #1;
    // requests taken at the coming rising edge
    for (int q = 0; q < `FDAM_NUM_IN; q++) begin
      if (request_read[q]) begin
        if (!available_read[q]) begin
          record_error($sformatf("input queue %0d read while available_read was low", q));
        end
        if (rd_seen[q] >= item_cnt) begin
          record_error($sformatf("input queue %0d read more than %0d items", q, item_cnt));
        end else begin
          exp_addr = in_base[q] + addr_t'(rd_seen[q]);
          if (request_data[q] != exp_addr) begin
            record_error($sformatf("Mismatch request_data[%0d]: got 0x%04h, expected 0x%04h",
                                   q, request_data[q], exp_addr));
          end
        end
        rng = xorshift32(rng);
        rd_due.push_back(cycle_cnt + 1 + (stall ? int'(rng[1:0]) : 0));
        rd_qid.push_back(qid_t'(q));
        rd_addr.push_back(request_data[q]);
        rd_seen[q]++;
      end
    end
    for (int k = 0; k < `FDAM_NUM_OUT; k++) begin
      if (request_write[k]) begin
        if (!available_write[k]) begin
          record_error($sformatf("output queue %0d wrote while available_write was low", k));
        end
        if (wr_seen[k] >= item_cnt) begin
          record_error($sformatf("output queue %0d wrote more than %0d results", k, item_cnt));
        end else begin
          i = wr_seen[k];
          exp_addr = out_base[k] + addr_t'(i);
          exp_data = (k == 0) ? op_a[i] + op_b[i] : op_a[i] ^ op_b[i];
          if (write_data[k].addr != exp_addr) begin
            record_error($sformatf("Mismatch write_data[%0d].addr: got 0x%04h, expected 0x%04h",
                                   k, write_data[k].addr, exp_addr));
          end
          if (write_data[k].data != exp_data) begin
            record_error($sformatf("Mismatch write_data[%0d].data: got 0x%08h, expected 0x%08h",
                                   k, write_data[k].data, exp_data));
          end
        end
        rng = xorshift32(rng);
        ack_due.push_back(cycle_cnt + 1 + (stall ? int'(rng[1:0]) : 0));
        ack_qid.push_back(qid_t'(`FDAM_NUM_IN + k));
        wr_seen[k]++;
      end
    end
    if (request_write[`FDAM_NUM_OUT]) begin
      if (!available_write[`FDAM_NUM_OUT]) record_error("status written while unavailable");
      if (status_seen != 0) record_error("more than one status write");
      if (res_acks_sent != 2 * item_cnt) begin
        record_error("status write came before every result write was acknowledged");
      end
      // done flag on top and total results in the low half
      exp_data = {1'b1, {(`FDAM_DATA_W - `FDAM_QTD_W - 1){1'b0}}, qtd_t'(2 * item_cnt)};
      if (write_data[`FDAM_NUM_OUT].addr != status_addr) begin
        record_error($sformatf("Mismatch write_data[2].addr: got 0x%04h, expected 0x%04h",
                               write_data[`FDAM_NUM_OUT].addr, status_addr));
      end
      if (write_data[`FDAM_NUM_OUT].data != exp_data) begin
        record_error($sformatf("Mismatch write_data[2].data: got 0x%08h, expected 0x%08h",
                               write_data[`FDAM_NUM_OUT].data, exp_data));
      end
      ack_due.push_back(cycle_cnt + 1);
      ack_qid.push_back(STATUS_QID);
      status_seen++;
    end
  endtask

  task automatic run_case(input int index, input int ptr);
    item_cnt = int'(case_mem[ptr]);
    in_base[0] = addr_t'(case_mem[ptr + 1]);
    in_base[1] = addr_t'(case_mem[ptr + 2]);
    out_base[0] = addr_t'(case_mem[ptr + 3]);
    out_base[1] = addr_t'(case_mem[ptr + 4]);
    status_addr = addr_t'(case_mem[ptr + 5]);
    stall = case_mem[ptr + 6][0];
    for (int i = 0; i < item_cnt; i++) begin
      op_a[i] = case_mem[ptr + HEADER_WORDS + 2 * i];
      op_b[i] = case_mem[ptr + HEADER_WORDS + 2 * i + 1];
      host_mem[in_base[0] + addr_t'(i)] = op_a[i];
      host_mem[in_base[1] + addr_t'(i)] = op_b[i];
    end
    case_errors = 0;
    clear_tracking();
    apply_reset();
    configure_and_start();
    // reset lands while reads are still in flight
    while (rd_seen[0] == 0) step_host();
    apply_reset();
    clear_tracking();
    configure_and_start();
    while (!status_acked) step_host();
    repeat (DRAIN_CYCLES) step_host();
    for (int q = 0; q < `FDAM_NUM_IN; q++) begin
      if (rd_seen[q] != item_cnt) begin
        record_error($sformatf("input queue %0d read %0d items, not %0d",
                               q, rd_seen[q], item_cnt));
      end
    end
    for (int k = 0; k < `FDAM_NUM_OUT; k++) begin
      if (wr_seen[k] != item_cnt) begin
        record_error($sformatf("output queue %0d wrote %0d results, not %0d",
                               k, wr_seen[k], item_cnt));
      end
    end
    if (status_seen != 1) record_error("status write missing");
    if (case_errors == 0) begin
      $display("case %0d: pass, %0d items", index, item_cnt);
      cases_passed++;
    end else begin
      $display("case %0d: fail, %0d errors", index, case_errors);
      cases_failed++;
    end
  endtask

  initial begin
    int ptr;
    int index;
    clk = 1'b0;
    reset = 1'b1;
    start = 1'b0;
    conf_valid = 1'b0;
    conf = '0;
    available_read = '0;
    available_write = '0;
    read_data_valid = 1'b0;
    read_queue_id = '0;
    read_data = '0;
    write_data_valid = 1'b0;
    write_queue_id = '0;
    rng = 32'd74;
    total_errors = 0;
    cases_passed = 0;
    cases_failed = 0;
    $readmemh("dv/fdam_cases.txt", case_mem);
    // 40 cycles per item plus fixed slack
    cycle_limit = 200;
    ptr = 0;
    while (case_mem[ptr] != '0) begin
      cycle_limit += 40 * int'(case_mem[ptr]);
      ptr += HEADER_WORDS + 2 * int'(case_mem[ptr]);
    end
    ptr = 0;
    index = 0;
    while (case_mem[ptr] != '0) begin
      run_case(index, ptr);
      ptr += HEADER_WORDS + 2 * item_cnt;
      index++;
    end
    $display("cases %0d, passed %0d, failed %0d, errors %0d",
             index, cases_passed, cases_failed, total_errors);
    if (total_errors == 0 && cases_failed == 0 && cases_passed > 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== dv/fdam_cases.txt ====
// header: count in_base0 in_base1 out_base0 out_base1 status_addr stall (1 = random back-pressure)
// then one line per item: operand_a operand_b; a count of 0 ends the list
00000004 00000100 00000200 00000300 00000400 00000500 00000000
00000001 00000002
FFFFFFFF 00000001
12345678 87654321
80000000 80000000
00000005 00001000 00001100 00001200 00001300 00001400 00000001
DEADBEEF 01020304
00000000 00000000
7FFFFFFF 00000001
A5A5A5A5 5A5A5A5A
0000FFFF FFFF0000
00000003 0000F000 0000F100 0000F200 0000F300 0000FF00 00000001
CAFEF00D 11111111
FFFFFFFE FFFFFFFF
00000010 00000020
00000000

// ==== fdam_accelerator.f ====
+incdir+hw
hw/fdam_conf_pkg.sv
hw/fdam_stream_pkg.sv
hw/fdam_reg_tree.sv
hw/fdam_input_queue.sv
hw/fdam_output_queue.sv
hw/fdam_dsm_controller.sv
hw/fdam_acc_user.sv
hw/fdam_accelerator.sv
dv/fdam_accelerator_tb.sv

// ==== hw/fdam_acc_user.sv ====
`timescale 1ns/1ps
`include "fdam_consts.svh"

module fdam_acc_user
  import fdam_stream_pkg::*;
(
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            start,
  input  logic [`FDAM_NUM_IN-1:0]         acc_user_done_rd_data,
  input  logic [`FDAM_NUM_IN-1:0]         acc_user_available_read,
  output logic [`FDAM_NUM_IN-1:0]         acc_user_request_read,
  input  data_t [`FDAM_NUM_IN-1:0]        acc_user_read_data,
  input  logic [`FDAM_NUM_IN-1:0]         acc_user_read_data_valid,
  input  logic [`FDAM_NUM_OUT-1:0]        acc_user_available_write,
  output logic [`FDAM_NUM_OUT-1:0]        acc_user_request_write,
  output data_t [`FDAM_NUM_OUT-1:0]       acc_user_write_data,
  output logic                            acc_user_done
);

  logic running;
  logic fire;
  logic push;

  // pop both operands together only when both results fit
  assign fire = running && (&acc_user_available_read) && (&acc_user_available_write);
  assign acc_user_request_read = {`FDAM_NUM_IN{fire}};

  // operands land one cycle after the pop
  assign push = &acc_user_read_data_valid;
  assign acc_user_request_write = {`FDAM_NUM_OUT{push}};
  assign acc_user_write_data[0] = acc_user_read_data[0] + acc_user_read_data[1];
  assign acc_user_write_data[1] = acc_user_read_data[0] ^ acc_user_read_data[1];

  always_ff @(posedge clk) begin
    if (reset) begin
      running <= 1'b0;
      acc_user_done <= 1'b0;
    end else if (start) begin
      running <= 1'b1;
      acc_user_done <= 1'b0;
    end else if (running && (&acc_user_done_rd_data) && !push) begin
      acc_user_done <= 1'b1;
    end
  end

endmodule

// ==== hw/fdam_accelerator.sv ====
`timescale 1ns/1ps
`include "fdam_consts.svh"

module fdam_accelerator
  import fdam_conf_pkg::*;
  import fdam_stream_pkg::*;
(
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          start,
  input  logic                          conf_valid,
  input  conf_word_t                    conf,
  input  logic [`FDAM_NUM_IN-1:0]       available_read,
  output logic [`FDAM_NUM_IN-1:0]       request_read,
  output addr_t [`FDAM_NUM_IN-1:0]      request_data,
  input  logic                          read_data_valid,
  input  qid_t                          read_queue_id,
  input  data_t                         read_data,
  input  logic [`FDAM_NUM_OUT:0]        available_write,
  output logic [`FDAM_NUM_OUT:0]        request_write,
  output wr_beat_t [`FDAM_NUM_OUT:0]    write_data,
  input  logic                          write_data_valid,
  input  qid_t                          write_queue_id
);

  // fan-out slots: input queues, output queues, controller, kernel, top
  localparam int DSM_IDX = `FDAM_NUM_IN + `FDAM_NUM_OUT;
  localparam int ACC_IDX = DSM_IDX + 1;
  localparam int TOP_IDX = DSM_IDX + 2;

  logic reset_q [TOP_IDX + 1];
  logic start_q [ACC_IDX + 1];
  logic acc_done_q [`FDAM_NUM_OUT];

  logic conf_valid_q;
  conf_word_t conf_q;
  logic read_data_valid_q;
  qid_t read_queue_id_q;
  data_t read_data_q;
  logic write_data_valid_q;
  qid_t write_queue_id_q;

  logic [`FDAM_NUM_IN-1:0] in_done;
  logic [`FDAM_NUM_IN-1:0] rd_pending;
  logic [`FDAM_NUM_OUT-1:0] out_done;
  logic [`FDAM_NUM_OUT-1:0] wr_pending;
  logic [`FDAM_NUM_IN-1:0] acc_avail_read;
  logic [`FDAM_NUM_IN-1:0] acc_req_read;
  data_t [`FDAM_NUM_IN-1:0] acc_rd_data;
  logic [`FDAM_NUM_IN-1:0] acc_rd_valid;
  logic [`FDAM_NUM_OUT-1:0] acc_avail_write;
  logic [`FDAM_NUM_OUT-1:0] acc_req_write;
  data_t [`FDAM_NUM_OUT-1:0] acc_wr_data;
  logic acc_done;

  // ==========================================================================
  // host input registers
  // ==========================================================================

  always_ff @(posedge clk) begin
    if (reset_q[TOP_IDX]) begin
      conf_valid_q <= 1'b0;
      read_data_valid_q <= 1'b0;
      write_data_valid_q <= 1'b0;
    end else begin
      conf_valid_q <= conf_valid;
      read_data_valid_q <= read_data_valid;
      write_data_valid_q <= write_data_valid;
    end
  end

  always_ff @(posedge clk) begin
    conf_q <= conf;
    read_queue_id_q <= read_queue_id;
    read_data_q <= read_data;
    write_queue_id_q <= write_queue_id;
  end

  fdam_reg_tree #(.payload_t(logic), .OUTS(TOP_IDX + 1)) u_reset_tree (
    .clk (clk),
    .in  (reset),
    .out (reset_q)
  );

  fdam_reg_tree #(.payload_t(logic), .OUTS(ACC_IDX + 1)) u_start_tree (
    .clk (clk),
    .in  (start),
    .out (start_q)
  );

  fdam_reg_tree #(.payload_t(logic), .OUTS(`FDAM_NUM_OUT)) u_done_tree (
    .clk (clk),
    .in  (acc_done),
    .out (acc_done_q)
  );

  // ==========================================================================
  // queues, controller and kernel
  // ==========================================================================

  for (genvar i = 0; i < `FDAM_NUM_IN; i++) begin : g_in_queue
    fdam_input_queue #(.ID_QUEUE(i)) u_input_queue (
      .clk                      (clk),
      .reset                    (reset_q[i]),
      .start                    (start_q[i]),
      .conf_valid               (conf_valid_q),
      .conf                     (conf_q),
      .available_read           (available_read[i]),
      .request_read             (request_read[i]),
      .request_data             (request_data[i]),
      .read_data_valid          (read_data_valid_q),
      .read_queue_id            (read_queue_id_q),
      .read_data                (read_data_q),
      .has_rd_pending           (rd_pending[i]),
      .acc_user_available_read  (acc_avail_read[i]),
      .acc_user_request_read    (acc_req_read[i]),
      .acc_user_read_data       (acc_rd_data[i]),
      .acc_user_read_data_valid (acc_rd_valid[i]),
      .done                     (in_done[i])
    );
  end

  for (genvar i = 0; i < `FDAM_NUM_OUT; i++) begin : g_out_queue
    fdam_output_queue #(.ID_QUEUE(`FDAM_NUM_IN + i)) u_output_queue (
      .clk                      (clk),
      .reset                    (reset_q[`FDAM_NUM_IN + i]),
      .start                    (start_q[`FDAM_NUM_IN + i]),
      .conf_valid               (conf_valid_q),
      .conf                     (conf_q),
      .available_write          (available_write[i]),
      .request_write            (request_write[i]),
      .write_data               (write_data[i]),
      .write_data_valid         (write_data_valid_q),
      .write_queue_id           (write_queue_id_q),
      .has_wr_pending           (wr_pending[i]),
      .acc_user_available_write (acc_avail_write[i]),
      .acc_user_request_write   (acc_req_write[i]),
      .acc_user_write_data      (acc_wr_data[i]),
      .acc_user_done            (acc_done_q[i]),
      .done                     (out_done[i])
    );
  end

  fdam_dsm_controller #(.ID_QUEUE(DSM_IDX)) u_dsm_controller (
    .clk              (clk),
    .reset            (reset_q[DSM_IDX]),
    .start            (start_q[DSM_IDX]),
    .conf_valid       (conf_valid_q),
    .conf             (conf_q),
    .done_rd          (in_done),
    .done_wr          (out_done),
    .has_rd_pending   (rd_pending),
    .has_wr_pending   (wr_pending),
    .done_acc         (acc_done),
    .available_write  (available_write[`FDAM_NUM_OUT]),
    .request_write    (request_write[`FDAM_NUM_OUT]),
    .write_data       (write_data[`FDAM_NUM_OUT]),
    .write_data_valid (write_data_valid_q),
    .write_queue_id   (write_queue_id_q)
  );

  fdam_acc_user u_acc_user (
    .clk                      (clk),
    .reset                    (reset_q[ACC_IDX]),
    .start                    (start_q[ACC_IDX]),
    .acc_user_done_rd_data    (in_done),
    .acc_user_available_read  (acc_avail_read),
    .acc_user_request_read    (acc_req_read),
    .acc_user_read_data       (acc_rd_data),
    .acc_user_read_data_valid (acc_rd_valid),
    .acc_user_available_write (acc_avail_write),
    .acc_user_request_write   (acc_req_write),
    .acc_user_write_data      (acc_wr_data),
    .acc_user_done            (acc_done)
  );

endmodule

// ==== hw/fdam_conf_pkg.sv ====
`include "fdam_consts.svh"

package fdam_conf_pkg;

  typedef logic [`FDAM_QID_W-1:0] qid_t;
  typedef logic [`FDAM_ADDR_W-1:0] addr_t;
  typedef logic [`FDAM_QTD_W-1:0] qtd_t;

  // host configuration word, queue id in the top byte
  typedef struct packed {
    qid_t qid;
    addr_t base;
    qtd_t count;
  } conf_word_t;

  // true when the word targets block id
  function automatic logic conf_match(input conf_word_t word, input int id);
    return word.qid == qid_t'(id);
  endfunction

endpackage

// ==== hw/fdam_consts.svh ====
`ifndef FDAM_CONSTS_SVH
`define FDAM_CONSTS_SVH

// ==========================================================================
// field widths
// ==========================================================================

`define FDAM_ADDR_W 16
`define FDAM_DATA_W 32
`define FDAM_QTD_W 16
`define FDAM_QID_W 8

// ==========================================================================
// queue counts
// ==========================================================================

// write channel FDAM_NUM_OUT is the status channel
`define FDAM_NUM_IN 2
`define FDAM_NUM_OUT 2

// register depth of reset, start and done fan-out
`define FDAM_TREE_LEVELS 2

`endif

// ==== hw/fdam_dsm_controller.sv ====
`timescale 1ns/1ps
`include "fdam_consts.svh"

module fdam_dsm_controller
  import fdam_conf_pkg::*;
  import fdam_stream_pkg::*;
#(
  parameter int ID_QUEUE = `FDAM_NUM_IN + `FDAM_NUM_OUT
) (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     start,
  input  logic                     conf_valid,
  input  conf_word_t               conf,
  input  logic [`FDAM_NUM_IN-1:0]  done_rd,
  input  logic [`FDAM_NUM_OUT-1:0] done_wr,
  input  logic [`FDAM_NUM_IN-1:0]  has_rd_pending,
  input  logic [`FDAM_NUM_OUT-1:0] has_wr_pending,
  input  logic                     done_acc,
  input  logic                     available_write,
  output logic                     request_write,
  output wr_beat_t                 write_data,
  input  logic                     write_data_valid,
  input  qid_t                     write_queue_id
);

  typedef enum logic [1:0] {ST_IDLE, ST_RUN, ST_POST, ST_WAIT_ACK} state_t;

  state_t state;
  addr_t status_addr_q;
  qtd_t total_q;
  status_t status;
  logic result_ack;
  logic all_done;

  // acks from the output queue id range
  assign result_ack = write_data_valid &&
                      (write_queue_id >= qid_t'(`FDAM_NUM_IN)) &&
                      (write_queue_id < qid_t'(`FDAM_NUM_IN + `FDAM_NUM_OUT));
  assign all_done = done_acc && (&done_rd) && (&done_wr) &&
                    !(|has_rd_pending) && !(|has_wr_pending);

  assign status = '{done: 1'b1, reserved: '0, total: total_q};
  assign request_write = (state == ST_POST) && available_write;
  assign write_data = '{addr: status_addr_q, data: data_t'(status)};

  always_ff @(posedge clk) begin
    if (conf_valid && conf_match(conf, ID_QUEUE)) status_addr_q <= conf.base;
  end

  // ==========================================================================
  // completion FSM
  // ==========================================================================

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_IDLE;
      total_q <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (start) begin
            total_q <= '0;
            state <= ST_RUN;
          end
        end
        ST_RUN: begin
          if (result_ack) total_q <= total_q + 1'b1;
          if (all_done) state <= ST_POST;
        end
        ST_POST: begin
          if (request_write) state <= ST_WAIT_ACK;
        end
        ST_WAIT_ACK: begin
          if (write_data_valid && (write_queue_id == qid_t'(ID_QUEUE))) state <= ST_IDLE;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

// ==== hw/fdam_input_queue.sv ====
`timescale 1ns/1ps
`include "fdam_consts.svh"

module fdam_input_queue
  import fdam_conf_pkg::*;
  import fdam_stream_pkg::*;
#(
  parameter int ID_QUEUE = 0
) (
  input  logic       clk,
  input  logic       reset,
  input  logic       start,
  input  logic       conf_valid,
  input  conf_word_t conf,
  input  logic       available_read,
  output logic       request_read,
  output addr_t      request_data,
  input  logic       read_data_valid,
  input  qid_t       read_queue_id,
  input  data_t      read_data,
  output logic       has_rd_pending,
  output logic       acc_user_available_read,
  input  logic       acc_user_request_read,
  output data_t      acc_user_read_data,
  output logic       acc_user_read_data_valid,
  output logic       done
);

  addr_t base_q;
  qtd_t count_q;
  qtd_t req_cnt;
  qtd_t pop_cnt;
  logic running;
  logic [1:0] inflight;
  logic [1:0] occ;
  logic wr_ptr;
  logic rd_ptr;
  data_t fifo_mem [2];
  logic accept;
  logic pop;

  assign accept = read_data_valid && (read_queue_id == qid_t'(ID_QUEUE));
  assign pop = acc_user_request_read && (occ != 2'd0);

  // outstanding reads never exceed free buffer space
  assign request_read = running && (req_cnt != count_q) && available_read &&
                        (({1'b0, inflight} + {1'b0, occ}) < 3'd2);
  assign request_data = base_q + req_cnt;
  assign has_rd_pending = (inflight != 2'd0);
  assign acc_user_available_read = (occ != 2'd0);

  always_ff @(posedge clk) begin
    if (conf_valid && conf_match(conf, ID_QUEUE)) begin
      base_q <= conf.base;
      count_q <= conf.count;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) fifo_mem[wr_ptr] <= read_data;
    if (pop) acc_user_read_data <= fifo_mem[rd_ptr];
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      running <= 1'b0;
      req_cnt <= '0;
      pop_cnt <= '0;
      inflight <= '0;
      occ <= '0;
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      acc_user_read_data_valid <= 1'b0;
      done <= 1'b0;
    end else begin
      acc_user_read_data_valid <= pop;
      inflight <= inflight + {1'b0, request_read} - {1'b0, accept};
      occ <= occ + {1'b0, accept} - {1'b0, pop};
      if (accept) wr_ptr <= ~wr_ptr;
      if (pop) rd_ptr <= ~rd_ptr;
      if (start) begin
        running <= 1'b1;
        req_cnt <= '0;
        pop_cnt <= '0;
        done <= 1'b0;
      end else begin
        if (request_read) req_cnt <= req_cnt + 1'b1;
        if (pop) pop_cnt <= pop_cnt + 1'b1;
        // every item handed to the kernel
        if (running && (pop_cnt == count_q)) done <= 1'b1;
      end
    end
  end

endmodule

// ==== hw/fdam_output_queue.sv ====
`timescale 1ns/1ps
`include "fdam_consts.svh"

module fdam_output_queue
  import fdam_conf_pkg::*;
  import fdam_stream_pkg::*;
#(
  parameter int ID_QUEUE = `FDAM_NUM_IN
) (
  input  logic       clk,
  input  logic       reset,
  input  logic       start,
  input  logic       conf_valid,
  input  conf_word_t conf,
  input  logic       available_write,
  output logic       request_write,
  output wr_beat_t   write_data,
  input  logic       write_data_valid,
  input  qid_t       write_queue_id,
  output logic       has_wr_pending,
  output logic       acc_user_available_write,
  input  logic       acc_user_request_write,
  input  data_t      acc_user_write_data,
  input  logic       acc_user_done,
  output logic       done
);

  addr_t base_q;
  qtd_t wr_cnt;
  qtd_t ack_cnt;
  logic [1:0] occ;
  logic [1:0] occ_next;
  logic wr_ptr;
  logic rd_ptr;
  data_t fifo_mem [2];
  logic acc_done_seen;
  logic ack;

  assign ack = write_data_valid && (write_queue_id == qid_t'(ID_QUEUE));
  assign request_write = (occ != 2'd0) && available_write;
  assign write_data = '{addr: base_q + wr_cnt, data: fifo_mem[rd_ptr]};
  assign has_wr_pending = (wr_cnt != ack_cnt);

  // room is judged on next cycle occupancy, the kernel pushes a cycle after it pops
  assign occ_next = occ + {1'b0, acc_user_request_write} - {1'b0, request_write};
  assign acc_user_available_write = (occ_next != 2'd2);

  always_ff @(posedge clk) begin
    if (conf_valid && conf_match(conf, ID_QUEUE)) base_q <= conf.base;
    if (acc_user_request_write) fifo_mem[wr_ptr] <= acc_user_write_data;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_cnt <= '0;
      ack_cnt <= '0;
      occ <= '0;
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      acc_done_seen <= 1'b0;
      done <= 1'b0;
    end else begin
      occ <= occ_next;
      if (acc_user_request_write) wr_ptr <= ~wr_ptr;
      if (request_write) rd_ptr <= ~rd_ptr;
      if (start) begin
        wr_cnt <= '0;
        ack_cnt <= '0;
        acc_done_seen <= 1'b0;
        done <= 1'b0;
      end else begin
        if (request_write) wr_cnt <= wr_cnt + 1'b1;
        if (ack) ack_cnt <= ack_cnt + 1'b1;
        if (acc_user_done) acc_done_seen <= 1'b1;
        // drained and every write acknowledged
        if (acc_done_seen && (occ == 2'd0) && !has_wr_pending) done <= 1'b1;
      end
    end
  end

endmodule

// ==== hw/fdam_reg_tree.sv ====
`timescale 1ns/1ps
`include "fdam_consts.svh"

module fdam_reg_tree #(
  parameter type payload_t = logic,
  parameter int OUTS = 2
) (
  input  logic     clk,
  input  payload_t in,
  output payload_t out [OUTS]
);

  localparam int LEVELS = `FDAM_TREE_LEVELS;

  // smallest fan-out per flop that reaches OUTS copies in LEVELS stages
  function automatic int branch_factor();
    int f;
    f = 1;
    while (f ** LEVELS < OUTS) begin
      f = f + 1;
    end
    return f;
  endfunction

  function automatic int copies(input int level);
    int n;
    n = branch_factor() ** level;
    return (n < OUTS) ? n : OUTS;
  endfunction

  payload_t stage_q [LEVELS][OUTS];

  for (genvar l = 0; l < LEVELS; l++) begin : g_level
    for (genvar j = 0; j < copies(l + 1); j++) begin : g_copy
      if (l == 0) begin : g_root
        always_ff @(posedge clk) stage_q[0][j] <= in;
      end else begin : g_branch
        always_ff @(posedge clk) stage_q[l][j] <= stage_q[l-1][j / branch_factor()];
      end
    end
  end

  assign out = stage_q[LEVELS-1];

endmodule

// ==== hw/fdam_stream_pkg.sv ====
`include "fdam_consts.svh"

package fdam_stream_pkg;

  typedef logic [`FDAM_DATA_W-1:0] data_t;

  // one write request, address over data
  typedef struct packed {
    fdam_conf_pkg::addr_t addr;
    data_t data;
  } wr_beat_t;

  // completion record posted on the status channel
  typedef struct packed {
    logic done;
    logic [`FDAM_DATA_W-`FDAM_QTD_W-2:0] reserved;
    fdam_conf_pkg::qtd_t total;
  } status_t;

endpackage

// ==== run.sh ====
#!/bin/sh
# build and run the fdam_accelerator testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f fdam_accelerator.f \
  --top-module fdam_accelerator_tb --Mdir obj_dir -o fdam_sim

./obj_dir/fdam_sim > sim.log 2>&1
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
  exit 1
fi
exit 0
